//--- dv/pic_patterns.txt
# op operand expected, all hex; writes and req ignore the expected column
# ack expects the vector byte, irq expects interrupt_to_cpu
icw1 00 00
icwn 08 00
ocw1 00 00
req  08 00
irq  00 01
ack  00 0b
req  20 00
irq  00 00
ocw2 20 00
irq  00 01
ack  00 0d
ocw2 20 00
req  00 00
ocw1 04 00
req  44 00
irq  00 01
ack  00 0e
ocw2 20 00
ocw1 ff 00
irq  00 00
req  12 00
ocw1 00 00
irq  00 01
ack  00 09
req  10 00
irq  00 00
ocw2 61 00
irq  00 01
ack  00 0c
ocw2 64 00
ocw2 c3 00
req  21 00
ack  00 0d
ocw2 20 00
ocw2 c7 00
icw1 01 00
icwn 10 00
icwn 02 00
ocw1 00 00
ocw2 80 00
req  44 00
irq  00 01
ack  00 12
ack  00 16
ack  00 12
ocw2 00 00
ocw2 c7 00
req  00 00
irq  00 00
icw1 00 00
ocw1 00 00
icwn 08 00
req  08 00
irq  00 00
ack  00 0f
ocw1 00 00
irq  00 01
ack  00 0b
ocw2 20 00
req  00 00
irq  00 00

//--- tb.f
+incdir+include
hdl/pic_pkg.sv
hdl/priority_resolver.sv
hdl/command_decoder.sv
hdl/in_service_tracker.sv
hdl/acknowledge_sequencer.sv
hdl/pic_top.sv
dv/pic_tb.sv

//--- Bender.yml
package:
  name: pic

export_include_dirs:
  - include

sources:
  - files:
      - hdl/pic_pkg.sv
      - hdl/priority_resolver.sv
      - hdl/command_decoder.sv
      - hdl/in_service_tracker.sv
      - hdl/acknowledge_sequencer.sv
      - hdl/pic_top.sv
  - target: simulation
    files:
      - dv/pic_tb.sv

//--- dv/pic_tb.sv
`timescale 1ns/1ps

`include "pic_consts.svh"

module pic_tb import pic_pkg::*; ();

    logic                   write_initial_command_word_2_4;
    logic                   reset;
    host_write_t            host_write;
    logic [`PIC_LEVELS-1:0] interrupt_request;
    logic                   interrupt_acknowledge_n;
    logic                   interrupt_to_cpu;
    vector_out_t            vector_out;

    // one entry per operation line of the pattern file
    logic [63:0] op_names[$];
    logic [7:0]  operands[$];
    logic [7:0]  expects[$];

    integer seed;
    integer gap;
    integer cycles;
    integer cycle_limit;

    pic_top UUT (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .reset                          (reset),
        .host_write                     (host_write),
        .interrupt_request              (interrupt_request),
        .interrupt_acknowledge_n        (interrupt_acknowledge_n),
        .interrupt_to_cpu               (interrupt_to_cpu),
        .vector_out                     (vector_out)
    );

    initial begin
        write_initial_command_word_2_4 = 1'b0;
        forever #20 write_initial_command_word_2_4 = ~write_initial_command_word_2_4;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input logic [7:0] actual, input logic [7:0] want,
                               input string what);
        if (actual !== want) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, want);
            abort_run();
        end
    endtask

    // run limit counted from time zero
    always @(posedge write_initial_command_word_2_4) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the patterns did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic load_patterns();
        integer        fd;
        integer        fields;
        logic [63:0]   word;
        logic [7:0]    arg;
        logic [7:0]    want;
        logic [1023:0] rest_of_line;

        fd = $fopen("dv/pic_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file dv/pic_patterns.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            fields = $fscanf(fd, "%s", word);
            if (fields == 1) begin
                if (word == "#") begin
                    // skip the rest of a comment line
                    fields = $fgets(rest_of_line, fd);
                end else begin
                    fields = $fscanf(fd, "%h %h", arg, want);
                    if (fields != 2) begin
                        $display("Pattern line for operation %0s is missing a column", word);
                        abort_run();
                    end
                    op_names.push_back(word);
                    operands.push_back(arg);
                    expects.push_back(want);
                end
            end
        end
        $fclose(fd);
    endtask

    // single write strobe before returning to idle
    task automatic send_command(input cmd_kind_t kind, input logic [7:0] data);
        @(posedge write_initial_command_word_2_4);
        host_write.kind <= kind;
        host_write.data <= data;
        @(posedge write_initial_command_word_2_4);
        host_write.kind <= CMD_NONE;
        host_write.data <= 8'h00;
    endtask

    task automatic set_requests(input logic [7:0] lines);
        @(posedge write_initial_command_word_2_4);
        interrupt_request <= lines;
    endtask

    // IRR and interrupt output are two register stages deep
    task automatic expect_interrupt(input logic [7:0] want);
        repeat (3) @(posedge write_initial_command_word_2_4);
        @(negedge write_initial_command_word_2_4);
        check_value({7'd0, interrupt_to_cpu}, want, "interrupt_to_cpu");
    endtask

    // two INTA pulses with every phase two cycles long
    task automatic run_acknowledge(input logic [7:0] want);
        logic vector_seen;

        vector_seen = 1'b0;
        @(posedge write_initial_command_word_2_4);
        interrupt_acknowledge_n <= 1'b0;
        repeat (2) begin
            @(negedge write_initial_command_word_2_4);
            check_value({7'd0, vector_out.valid}, 8'h00, "vector valid in the first pulse");
            @(posedge write_initial_command_word_2_4);
        end
        interrupt_acknowledge_n <= 1'b1;
        repeat (2) @(posedge write_initial_command_word_2_4);
        interrupt_acknowledge_n <= 1'b0;
        repeat (2) begin
            @(negedge write_initial_command_word_2_4);
            if (vector_out.valid) begin
                vector_seen = 1'b1;
                check_value(vector_out.data, want, "vector byte");
            end
            @(posedge write_initial_command_word_2_4);
        end
        interrupt_acknowledge_n <= 1'b1;
        if (!vector_seen) begin
            $display("The vector byte never became valid during the second acknowledge pulse");
            abort_run();
        end
        repeat (2) @(posedge write_initial_command_word_2_4);
    endtask

    task automatic run_operation(input logic [63:0] name, input logic [7:0] arg,
                                 input logic [7:0] want);
        case (name)
            "icw1": send_command(CMD_ICW1, arg);
            "icwn": send_command(CMD_ICW_NEXT, arg);
            "ocw1": send_command(CMD_OCW1, arg);
            "ocw2": send_command(CMD_OCW2, arg);
            "req":  set_requests(arg);
            "ack":  run_acknowledge(want);
            "irq":  expect_interrupt(want);
            default: begin
                $display("Unknown operation %0s in the pattern file", name);
                abort_run();
            end
        endcase
    endtask

    initial begin
        seed                    = 32'h8696ef29;
        cycles                  = 0;
        cycle_limit             = 0;
        reset                   = 1'b1;
        host_write.kind         = CMD_NONE;
        host_write.data         = 8'h00;
        interrupt_request       = '0;
        interrupt_acknowledge_n = 1'b1;

        load_patterns();
        cycle_limit = 20 * op_names.size() + 50;

        repeat (5) @(posedge write_initial_command_word_2_4);
        reset <= 1'b0;

        for (int i = 0; i < op_names.size(); i++) begin
            // random idle gap between operations
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge write_initial_command_word_2_4);
            run_operation(op_names[i], operands[i], expects[i]);
        end

        repeat (4) @(posedge write_initial_command_word_2_4);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- hdl/pic_top.sv
`timescale 1ns/1ps

`include "pic_consts.svh"

module pic_top import pic_pkg::*; (
    input  logic                   write_initial_command_word_2_4,
    input  logic                   reset,
    input  host_write_t            host_write,
    input  logic [`PIC_LEVELS-1:0] interrupt_request,
    input  logic                   interrupt_acknowledge_n,
    output logic                   interrupt_to_cpu,
    output vector_out_t            vector_out
);

    pic_config_t                pic_config;
    logic [`PIC_LEVELS-1:0]     interrupt_mask;
    ocw2_cmd_t                  ocw2_cmd;
    ack_events_t                ack_events;
    logic [`PIC_LEVEL_BITS-1:0] ack_level;

    // host side, init sequence and OCW decode
    command_decoder u_command_decoder (
        .clock          (write_initial_command_word_2_4),
        .reset          (reset),
        .host_write     (host_write),
        .pic_config     (pic_config),
        .interrupt_mask (interrupt_mask),
        .ocw2_cmd       (ocw2_cmd)
    );

    // IRR, ISR and priority
    in_service_tracker u_in_service_tracker (
        .clock             (write_initial_command_word_2_4),
        .reset             (reset),
        .pic_config        (pic_config),
        .interrupt_mask    (interrupt_mask),
        .interrupt_request (interrupt_request),
        .ocw2_cmd          (ocw2_cmd),
        .ack_events        (ack_events),
        .ack_level         (ack_level),
        .interrupt_to_cpu  (interrupt_to_cpu)
    );

    // CPU side, INTA pulses and vector byte
    acknowledge_sequencer u_acknowledge_sequencer (
        .clock                   (write_initial_command_word_2_4),
        .reset                   (reset),
        .pic_config              (pic_config),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .ack_level               (ack_level),
        .ack_events              (ack_events),
        .vector_out              (vector_out)
    );

endmodule

//--- hdl/acknowledge_sequencer.sv
`timescale 1ns/1ps

`include "pic_consts.svh"

module acknowledge_sequencer import pic_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  pic_config_t                pic_config,
    input  logic                       interrupt_acknowledge_n,
    input  logic [`PIC_LEVEL_BITS-1:0] ack_level,
    output ack_events_t                ack_events,
    output vector_out_t                vector_out
);

    ack_state_t ack_state;
    logic       ack_n_prev;
    logic       ack_falling;
    logic       ack_rising;

    assign ack_falling = ack_n_prev & ~interrupt_acknowledge_n;
    assign ack_rising  = ~ack_n_prev & interrupt_acknowledge_n;

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_n_prev <= 1'b1;
            ack_state  <= ACK_IDLE;
        end else begin
            ack_n_prev <= interrupt_acknowledge_n;

            // a re-init drops any sequence in flight
            if (!pic_config.ready) begin
                ack_state <= ACK_IDLE;
            end else begin
                case (ack_state)
                    ACK_IDLE: begin
                        if (ack_falling) begin
                            ack_state <= ACK_FIRST;
                        end
                    end
                    ACK_FIRST: begin
                        if (ack_rising) begin
                            ack_state <= ACK_SECOND;
                        end
                    end
                    ACK_SECOND: begin
                        if (ack_rising) begin
                            ack_state <= ACK_IDLE;
                        end
                    end
                    default: begin
                        ack_state <= ACK_IDLE;
                    end
                endcase
            end
        end
    end

    always_comb begin
        ack_events.start  = pic_config.ready && (ack_state == ACK_IDLE) && ack_falling;
        ack_events.done   = pic_config.ready && (ack_state == ACK_SECOND) && ack_rising;
        // IRR is held from the first falling edge through done
        ack_events.freeze = ack_events.start || (ack_state != ACK_IDLE);
    end

    // vector byte only while the second pulse is low
    always_comb begin
        vector_out.valid = (ack_state == ACK_SECOND) && !interrupt_acknowledge_n;
        if (vector_out.valid) begin
            vector_out.data = {pic_config.base, ack_level};
        end else begin
            vector_out.data = '0;
        end
    end

endmodule

//--- hdl/in_service_tracker.sv
`timescale 1ns/1ps

`include "pic_consts.svh"

module in_service_tracker import pic_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  pic_config_t                pic_config,
    input  logic [`PIC_LEVELS-1:0]     interrupt_mask,
    input  logic [`PIC_LEVELS-1:0]     interrupt_request,
    input  ocw2_cmd_t                  ocw2_cmd,
    input  ack_events_t                ack_events,
    output logic [`PIC_LEVEL_BITS-1:0] ack_level,
    output logic                       interrupt_to_cpu
);

    logic [`PIC_LEVELS-1:0]     request_reg;
    logic [`PIC_LEVELS-1:0]     in_service;
    logic [`PIC_LEVELS-1:0]     pending;
    logic                       auto_rotate;
    logic [`PIC_LEVEL_BITS-1:0] lowest_level;
    logic                       ack_real;

    logic                       req_found;
    logic [`PIC_LEVEL_BITS-1:0] req_level;
    logic                       isr_found;
    logic [`PIC_LEVEL_BITS-1:0] isr_level;

    logic [`PIC_LEVELS-1:0]     isr_set;
    logic [`PIC_LEVELS-1:0]     isr_clear;
    logic [`PIC_LEVEL_BITS-1:0] lowest_next;
    logic                       irq_pending;

    // rank 0 is the highest priority under the current rotation
    function automatic logic [`PIC_LEVEL_BITS-1:0] rank_of(
        input logic [`PIC_LEVEL_BITS-1:0] lvl,
        input logic [`PIC_LEVEL_BITS-1:0] lowest
    );
        return lvl - lowest - `PIC_LEVEL_BITS'(1);
    endfunction

    assign pending = request_reg & ~interrupt_mask;

    priority_resolver u_request_resolver (
        .levels       (pending),
        .lowest_level (lowest_level),
        .found        (req_found),
        .level        (req_level)
    );

    priority_resolver u_service_resolver (
        .levels       (in_service),
        .lowest_level (lowest_level),
        .found        (isr_found),
        .level        (isr_level)
    );

    // request must outrank everything already in service
    assign irq_pending = pic_config.ready && req_found &&
        (!isr_found || (rank_of(req_level, lowest_level) < rank_of(isr_level, lowest_level)));

    always_comb begin
        isr_set     = '0;
        isr_clear   = '0;
        lowest_next = lowest_level;

        if (ack_events.start && req_found) begin
            isr_set[req_level] = 1'b1;
        end

        // auto EOI at the end of the second INTA pulse
        if (ack_events.done && pic_config.auto_eoi && ack_real) begin
            isr_clear[ack_level] = 1'b1;
            if (auto_rotate) begin
                lowest_next = ack_level;
            end
        end

        if (ocw2_cmd.valid) begin
            case (ocw2_cmd.op)
                OP_NONSPEC_EOI: begin
                    if (isr_found) begin
                        isr_clear[isr_level] = 1'b1;
                    end
                end
                OP_ROTATE_NONSPEC_EOI: begin
                    if (isr_found) begin
                        isr_clear[isr_level] = 1'b1;
                        lowest_next          = isr_level;
                    end
                end
                OP_SPEC_EOI: begin
                    isr_clear[ocw2_cmd.level] = 1'b1;
                end
                OP_ROTATE_SPEC_EOI: begin
                    isr_clear[ocw2_cmd.level] = 1'b1;
                    lowest_next               = ocw2_cmd.level;
                end
                OP_SET_PRIORITY: begin
                    lowest_next = ocw2_cmd.level;
                end
                default: begin
                    lowest_next = lowest_next;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            request_reg      <= '0;
            in_service       <= '0;
            auto_rotate      <= 1'b0;
            lowest_level     <= `PIC_RESET_ROTATE;
            ack_real         <= 1'b0;
            interrupt_to_cpu <= 1'b0;
        end else begin
            // IRR follows the lines except during an acknowledge
            if (!ack_events.freeze) begin
                request_reg <= interrupt_request;
            end

            in_service   <= (in_service & ~isr_clear) | isr_set;
            lowest_level <= lowest_next;

            if (ocw2_cmd.valid && ocw2_cmd.op == OP_SET_AUTO_ROTATE) begin
                auto_rotate <= 1'b1;
            end else if (ocw2_cmd.valid && ocw2_cmd.op == OP_CLEAR_AUTO_ROTATE) begin
                auto_rotate <= 1'b0;
            end

            if (ack_events.start) begin
                ack_real <= req_found;
            end

            if (ack_events.done) begin
                interrupt_to_cpu <= 1'b0;
            end else if (!ack_events.freeze) begin
                interrupt_to_cpu <= irq_pending;
            end
        end
    end

    // level reported in the vector byte
    always_ff @(posedge clock) begin
        if (ack_events.start) begin
            ack_level <= req_found ? req_level : `PIC_SPURIOUS_LEVEL;
        end
    end

endmodule

//--- hdl/command_decoder.sv
`timescale 1ns/1ps

`include "pic_consts.svh"

module command_decoder import pic_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  host_write_t            host_write,
    output pic_config_t            pic_config,
    output logic [`PIC_LEVELS-1:0] interrupt_mask,
    output ocw2_cmd_t              ocw2_cmd
);

    init_state_t init_state;
    logic        icw4_needed;

    // OCWs only count once the init sequence is through
    logic ocw_allowed;
    assign ocw_allowed = (init_state == INIT_READY);

    always_ff @(posedge clock) begin
        if (reset) begin
            init_state     <= INIT_NEED_ICW1;
            icw4_needed    <= 1'b0;
            pic_config     <= '0;
            interrupt_mask <= `PIC_RESET_MASK;
            ocw2_cmd       <= '0;
        end else begin
            // OCW2 decode is a single cycle pulse
            ocw2_cmd.valid <= 1'b0;

            case (host_write.kind)
                CMD_ICW1: begin
                    // restarts init from any state
                    init_state     <= INIT_NEED_ICW2;
                    icw4_needed    <= host_write.data[`PIC_ICW1_IC4_BIT];
                    pic_config     <= '0;
                    interrupt_mask <= `PIC_RESET_MASK;
                end

                CMD_ICW_NEXT: begin
                    case (init_state)
                        INIT_NEED_ICW2: begin
                            pic_config.base <= host_write.data[7:8-`PIC_BASE_BITS];
                            if (icw4_needed) begin
                                init_state <= INIT_NEED_ICW4;
                            end else begin
                                init_state       <= INIT_READY;
                                pic_config.ready <= 1'b1;
                            end
                        end
                        INIT_NEED_ICW4: begin
                            pic_config.auto_eoi <= host_write.data[`PIC_ICW4_AEOI_BIT];
                            pic_config.ready    <= 1'b1;
                            init_state          <= INIT_READY;
                        end
                        // stray ICW outside the sequence
                        default: begin
                            init_state <= init_state;
                        end
                    endcase
                end

                CMD_OCW1: begin
                    if (ocw_allowed) begin
                        interrupt_mask <= host_write.data;
                    end
                end

                CMD_OCW2: begin
                    if (ocw_allowed) begin
                        ocw2_cmd.valid <= 1'b1;
                        ocw2_cmd.op    <= ocw2_op_t'(host_write.data[`PIC_OCW2_OP_LSB +: 3]);
                        ocw2_cmd.level <= host_write.data[`PIC_LEVEL_BITS-1:0];
                    end
                end

                default: begin
                    init_state <= init_state;
                end
            endcase
        end
    end

endmodule

//--- hdl/priority_resolver.sv
`timescale 1ns/1ps

`include "pic_consts.svh"

module priority_resolver (
    input  logic [`PIC_LEVELS-1:0]     levels,
    input  logic [`PIC_LEVEL_BITS-1:0] lowest_level,
    output logic                       found,
    output logic [`PIC_LEVEL_BITS-1:0] level
);

    // highest priority sits just above lowest_level, wrapping at 7
    always_comb begin
        logic [`PIC_LEVEL_BITS-1:0] idx;

        found = 1'b0;
        level = lowest_level;
        idx   = lowest_level;

        for (int i = 1; i <= `PIC_LEVELS; i++) begin
            // truncation gives the wrap, i = 8 lands back on lowest_level
            idx = lowest_level + `PIC_LEVEL_BITS'(i);
            if (!found && levels[idx]) begin
                found = 1'b1;
                level = idx;
            end
        end
    end

endmodule

//--- hdl/pic_pkg.sv
package pic_pkg;

    `include "pic_consts.svh"

    // kind of host strobe that goes with a data byte
    typedef enum logic [2:0] {
        CMD_NONE     = 3'd0,
        CMD_ICW1     = 3'd1,
        CMD_ICW_NEXT = 3'd2,
        CMD_OCW1     = 3'd3,
        CMD_OCW2     = 3'd4
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t  kind;
        logic [7:0] data;
    } host_write_t;

    typedef enum logic [1:0] {
        INIT_NEED_ICW1,
        INIT_NEED_ICW2,
        INIT_NEED_ICW4,
        INIT_READY
    } init_state_t;

    // OCW2 bits 7:5 (R, SL, EOI)
    typedef enum logic [2:0] {
        OP_CLEAR_AUTO_ROTATE  = 3'b000,
        OP_NONSPEC_EOI        = 3'b001,
        OP_NOP                = 3'b010,
        OP_SPEC_EOI           = 3'b011,
        OP_SET_AUTO_ROTATE    = 3'b100,
        OP_ROTATE_NONSPEC_EOI = 3'b101,
        OP_SET_PRIORITY       = 3'b110,
        OP_ROTATE_SPEC_EOI    = 3'b111
    } ocw2_op_t;

    typedef struct packed {
        logic                       valid;
        ocw2_op_t                   op;
        logic [`PIC_LEVEL_BITS-1:0] level;
    } ocw2_cmd_t;

    typedef struct packed {
        logic [`PIC_BASE_BITS-1:0] base;
        logic                      auto_eoi;
        logic                      ready;
    } pic_config_t;

    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_FIRST,
        ACK_SECOND
    } ack_state_t;

    typedef struct packed {
        logic freeze;
        logic start;
        logic done;
    } ack_events_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } vector_out_t;

endpackage

//--- include/pic_consts.svh
`ifndef PIC_CONSTS_SVH
`define PIC_CONSTS_SVH

// interrupt levels and the widths that follow from them
`define PIC_LEVELS          8
`define PIC_LEVEL_BITS      3
`define PIC_BASE_BITS       5

// reset values
`define PIC_RESET_ROTATE    3'd7
`define PIC_RESET_MASK      8'hFF

// level reported when the first acknowledge finds nothing pending
`define PIC_SPURIOUS_LEVEL  3'd7

// command byte field positions
`define PIC_ICW1_IC4_BIT    0
`define PIC_ICW4_AEOI_BIT   1
`define PIC_OCW2_OP_LSB     5

`endif
